// File: verilog/rvPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I core shared definitions
// Word, register, funct3 and lane types,
// the opcode classes and the control states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package rvPkg;

   // Data word for operands, results and memory data
   typedef logic [31:0] wordT;

   // Register index, rs1/rs2/rd fields
   typedef logic [4:0] regIdT;

   // Operation selector from instruction bits 14:12
   typedef logic [2:0] funct3T;

   // Latched instruction, bits 1:0 are always 2'b11 in RV32I
   typedef logic [31:2] instrWordT;

   // Byte lane offset within a word
   typedef logic [1:0] byteOffT;

   // One bit per byte lane of a write
   typedef logic [3:0] byteMaskT;

   // Instruction classes, encoded as the 5-bit major opcode (instr[6:2])
   typedef enum logic [4:0] {
      opLoad   = 5'b00000,
      opAluImm = 5'b00100,
      opAuipc  = 5'b00101,
      opStore  = 5'b01000,
      opAluReg = 5'b01100,
      opLui    = 5'b01101,
      opBranch = 5'b11000,
      opJalr   = 5'b11001,
      opJal    = 5'b11011,
      opSystem = 5'b11100,
      // Not a legal 32-bit major opcode, stands for anything unknown
      opOther  = 5'b11111
   } opClassT;

   // Control FSM states
   typedef enum logic [1:0] {
      fetchInstr,
      waitInstr,
      execute,
      waitMem
   } ctrlStateT;

endpackage

// File: verilog/decodeIf.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decoded instruction bundle
// From the decoder to ALU, load/store
// unit and control
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

interface decodeIf;

   rvPkg::opClassT opClass;
   rvPkg::funct3T  funct3;
   // instr[30], SUB/SRA select
   logic           altFunc;
   // instr[5], register form of an ALU op
   logic           regOp;
   rvPkg::regIdT   rdId;
   // Sign-extended immediates
   rvPkg::wordT    immI;
   rvPkg::wordT    immS;
   rvPkg::wordT    immB;
   rvPkg::wordT    immJ;
   rvPkg::wordT    immU;

   modport src (output opClass, funct3, altFunc, regOp, rdId,
                       immI, immS, immB, immJ, immU);

   modport dst (input  opClass, funct3, altFunc, regOp, rdId,
                       immI, immS, immB, immJ, immU);

endinterface

// File: verilog/instrDecode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction decoder
// Latches the fetched word, classifies the
// major opcode and builds the immediates
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module instrDecode (
   input  logic              clk,
   input  logic              instrLoad,
   input  rvPkg::wordT       memRdata,
   decodeIf.src              dec
);

   // Held for the whole execute and waitMem phases
   rvPkg::instrWordT instr;

   always_ff @(posedge clk) begin
      if (instrLoad) begin
         instr <= memRdata[31:2];
      end
   end

   // Map the major opcode onto the class enum
   always_comb begin
      case (instr[6:2])
         rvPkg::opLoad, rvPkg::opAluImm, rvPkg::opAuipc, rvPkg::opStore,
         rvPkg::opAluReg, rvPkg::opLui, rvPkg::opBranch, rvPkg::opJalr,
         rvPkg::opJal, rvPkg::opSystem: begin
            dec.opClass = rvPkg::opClassT'(instr[6:2]);
         end
         default: begin
            dec.opClass = rvPkg::opOther;
         end
      endcase
   end

   assign dec.funct3  = instr[14:12];
   assign dec.altFunc = instr[30];
   assign dec.regOp   = instr[5];
   assign dec.rdId    = instr[11:7];

   // The five immediate formats, all sign-extended from instr[31]
   assign dec.immU = {instr[31:12], 12'b0};
   assign dec.immI = {{21{instr[31]}}, instr[30:20]};
   assign dec.immS = {{21{instr[31]}}, instr[30:25], instr[11:7]};
   // B and J have an implicit zero LSB
   assign dec.immB = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign dec.immJ = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

   // Execute always follows a fetch, and the program holds only RV32I opcodes
   classKnown: assert property (
      @(posedge clk) instrLoad |=> dec.opClass != rvPkg::opOther
   );

endmodule

// File: verilog/regFile.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file, 32 x 32
// Two read ports latched at fetch, one
// write port, x0 hardwired to zero
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module regFile (
   input  logic         clk,
   input  logic         instrLoad,
   input  rvPkg::wordT  memRdata,
   input  logic         wrEn,
   input  rvPkg::regIdT wrId,
   input  rvPkg::wordT  wrData,
   output rvPkg::wordT  rs1Val,
   output rvPkg::wordT  rs2Val
);

   rvPkg::wordT  regs [32];
   rvPkg::regIdT rs1Id;
   rvPkg::regIdT rs2Id;

   // Source fields straight from the incoming instruction word
   assign rs1Id = memRdata[19:15];
   assign rs2Id = memRdata[24:20];

   // Writes to x0 are dropped
   always_ff @(posedge clk) begin
      if (wrEn && (wrId != '0)) begin
         regs[wrId] <= wrData;
      end
   end

   // Operands latch together with the instruction
   always_ff @(posedge clk) begin
      if (instrLoad) begin
         rs1Val <= (rs1Id == '0) ? '0 : regs[rs1Id];
         rs2Val <= (rs2Id == '0) ? '0 : regs[rs2Id];
      end
   end

   // Write-back happens in execute/waitMem, operand latch in waitInstr
   noWriteOnLatch: assert property (@(posedge clk) !(wrEn && instrLoad));

endmodule

// File: verilog/aluUnit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Integer ALU
// Adder, 33-bit compare, shared shifter,
// logic ops and the branch predicate
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module aluUnit (
   input  rvPkg::wordT rs1Val,
   input  rvPkg::wordT rs2Val,
   decodeIf.dst        dec,
   output rvPkg::wordT aluOut,
   output rvPkg::wordT sum,
   output logic        takeBranch
);

   rvPkg::wordT        aluIn2;
   logic [7:0]         funct3Is;
   logic [32:0]        minus;
   logic               lt;
   logic               ltu;
   logic               eq;
   rvPkg::wordT        shiftIn;
   logic signed [32:0] shifted;
   rvPkg::wordT        shifter;
   rvPkg::wordT        leftShift;
   logic               isSub;

   // Register operand for ALUreg and branches, I immediate otherwise
   assign aluIn2 = (dec.opClass == rvPkg::opAluReg || dec.opClass == rvPkg::opBranch) ?
                   rs2Val : dec.immI;

   // One-hot funct3
   assign funct3Is = 8'b1 << dec.funct3;

   // Also the JALR target and the plain ADD result
   assign sum = rs1Val + aluIn2;

   // rs1 - rs2 in 33 bits, carry out gives unsigned less-than
   assign minus = {1'b1, ~aluIn2} + {1'b0, rs1Val} + 33'b1;
   assign ltu   = minus[32];
   // Signs differ, then the sign of rs1 decides
   assign lt    = (rs1Val[31] ^ aluIn2[31]) ? rs1Val[31] : minus[32];
   assign eq    = (minus[31:0] == '0);

   // Left shifts run through the right shifter on reversed bits
   assign shiftIn = funct3Is[1] ? {<<{rs1Val}} : rs1Val;

   // Extra top bit carries the sign for SRA
   assign shifted   = $signed({dec.altFunc & rs1Val[31], shiftIn}) >>> aluIn2[4:0];
   assign shifter   = shifted[31:0];
   assign leftShift = {<<{shifter}};

   // instr[30] means SUB only in register form, in ADDI it is an immediate bit
   assign isSub = dec.altFunc & dec.regOp;

   // One-hot result select by funct3
   assign aluOut =
      (funct3Is[0] ? (isSub ? minus[31:0] : sum) : '0) |
      (funct3Is[1] ? leftShift                   : '0) |
      (funct3Is[2] ? {31'b0, lt}                 : '0) |
      (funct3Is[3] ? {31'b0, ltu}                : '0) |
      (funct3Is[4] ? rs1Val ^ aluIn2             : '0) |
      (funct3Is[5] ? shifter                     : '0) |
      (funct3Is[6] ? rs1Val | aluIn2             : '0) |
      (funct3Is[7] ? rs1Val & aluIn2             : '0);

   // BEQ BNE, then BLT BGE BLTU BGEU (funct3 2 and 3 unused)
   assign takeBranch =
      (funct3Is[0] &  eq)  |
      (funct3Is[1] & !eq)  |
      (funct3Is[4] &  lt)  |
      (funct3Is[5] & !lt)  |
      (funct3Is[6] &  ltu) |
      (funct3Is[7] & !ltu);

endmodule

// File: verilog/loadStore.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Load/store unit
// Address adder, store lane steering and
// mask, load extraction and extension
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module loadStore #(
   parameter int addrWidth = 24
) (
   input  rvPkg::wordT     rs1Val,
   input  rvPkg::wordT     rs2Val,
   input  rvPkg::wordT     memRdata,
   input  logic            storeEn,
   decodeIf.dst            dec,
   output rvPkg::wordT     lsAddr,
   output rvPkg::wordT     loadData,
   output rvPkg::wordT     memWdata,
   output rvPkg::byteMaskT memWmask
);

   rvPkg::wordT          offset;
   logic [addrWidth-1:0] addrLow;
   rvPkg::byteOffT       lane;
   logic                 byteAccess;
   logic                 halfAccess;
   logic [15:0]          loadHalf;
   logic [7:0]           loadByte;
   logic                 loadSign;

   // S immediate for stores, I immediate for loads
   assign offset  = (dec.opClass == rvPkg::opStore) ? dec.immS : dec.immI;
   assign addrLow = rs1Val[addrWidth-1:0] + offset[addrWidth-1:0];
   // Upper address bits read as zero
   assign lsAddr  = rvPkg::wordT'(addrLow);
   assign lane    = addrLow[1:0];

   // funct3[1:0]: 00 byte, 01 halfword, 10 word
   assign byteAccess = (dec.funct3[1:0] == 2'b00);
   assign halfAccess = (dec.funct3[1:0] == 2'b01);

   // Replicate the low bytes so every lane that can be written holds the data
   assign memWdata[7:0]   = rs2Val[7:0];
   assign memWdata[15:8]  = lane[0] ? rs2Val[7:0] : rs2Val[15:8];
   assign memWdata[23:16] = lane[1] ? rs2Val[7:0] : rs2Val[23:16];
   assign memWdata[31:24] = lane[0] ? rs2Val[7:0] :
                            lane[1] ? rs2Val[15:8] : rs2Val[31:24];

   // Write mask, live only in the execute cycle of a store
   always_comb begin
      if (!storeEn) begin
         memWmask = '0;
      end else if (byteAccess) begin
         memWmask = 4'b0001 << lane;
      end else if (halfAccess) begin
         memWmask = lane[1] ? 4'b1100 : 4'b0011;
      end else begin
         memWmask = 4'b1111;
      end
   end

   // Pick halfword then byte from the addressed lane
   assign loadHalf = lane[1] ? memRdata[31:16] : memRdata[15:0];
   assign loadByte = lane[0] ? loadHalf[15:8] : loadHalf[7:0];

   // funct3[2] set means LBU/LHU
   assign loadSign = !dec.funct3[2] & (byteAccess ? loadByte[7] : loadHalf[15]);

   assign loadData = byteAccess ? {{24{loadSign}}, loadByte} :
                     halfAccess ? {{16{loadSign}}, loadHalf} :
                                  memRdata;

endmodule

// File: verilog/fetchExecCtrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch/execute control
// Program counter, next-PC and write-back
// selection, four-state control FSM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module fetchExecCtrl #(
   parameter rvPkg::wordT resetAddr = '0,
   parameter int          addrWidth = 24
) (
   input  logic         clk,
   input  logic         reset,
   decodeIf.dst         dec,
   input  rvPkg::wordT  aluOut,
   input  rvPkg::wordT  sum,
   input  logic         takeBranch,
   input  rvPkg::wordT  lsAddr,
   input  rvPkg::wordT  loadData,
   input  logic         memRbusy,
   input  logic         memWbusy,
   output rvPkg::wordT  memAddr,
   output logic         memRstrb,
   output logic         instrLoad,
   output logic         storeEn,
   output logic         wrEn,
   output rvPkg::wordT  wrData
);

   rvPkg::ctrlStateT     state;
   logic [addrWidth-1:0] pc;
   logic [addrWidth-1:0] pcPlus4;
   rvPkg::wordT          immSel;
   logic [addrWidth-1:0] pcPlusImm;
   logic [addrWidth-1:0] pcNext;
   logic                 isLoad;
   logic                 isStore;
   logic                 isJalr;
   logic                 writesRd;

   assign isLoad  = (dec.opClass == rvPkg::opLoad);
   assign isStore = (dec.opClass == rvPkg::opStore);
   assign isJalr  = (dec.opClass == rvPkg::opJalr);

   assign pcPlus4 = pc + addrWidth'(4);

   // One adder serves JAL, AUIPC and branch targets
   always_comb begin
      case (dec.opClass)
         rvPkg::opJal:   immSel = dec.immJ;
         rvPkg::opAuipc: immSel = dec.immU;
         default:        immSel = dec.immB;
      endcase
   end
   assign pcPlusImm = pc + immSel[addrWidth-1:0];

   // JALR clears bit 0 of rs1 + imm
   always_comb begin
      if (isJalr) begin
         pcNext = {sum[addrWidth-1:1], 1'b0};
      end else if (dec.opClass == rvPkg::opJal ||
                   (dec.opClass == rvPkg::opBranch && takeBranch)) begin
         pcNext = pcPlusImm;
      end else begin
         pcNext = pcPlus4;
      end
   end

   // Write-back value, SYSTEM and unknown opcodes write nothing
   always_comb begin
      writesRd = 1'b1;
      case (dec.opClass)
         rvPkg::opLui:                  wrData = dec.immU;
         rvPkg::opAuipc:                wrData = rvPkg::wordT'(pcPlusImm);
         rvPkg::opAluImm, rvPkg::opAluReg: wrData = aluOut;
         rvPkg::opJal, rvPkg::opJalr:   wrData = rvPkg::wordT'(pcPlus4);
         rvPkg::opLoad:                 wrData = loadData;
         default: begin
            wrData   = '0;
            writesRd = 1'b0;
         end
      endcase
   end

   // Load data keeps being written through waitMem, the last write wins
   assign wrEn = writesRd && (state == rvPkg::execute || state == rvPkg::waitMem);

   // PC drives the bus during fetch, the load/store address otherwise
   assign memAddr = (state == rvPkg::fetchInstr || state == rvPkg::waitInstr) ?
                    rvPkg::wordT'(pc) : lsAddr;

   assign memRstrb  = (state == rvPkg::fetchInstr) || (state == rvPkg::execute && isLoad);
   assign instrLoad = (state == rvPkg::waitInstr) && !memRbusy;
   assign storeEn   = (state == rvPkg::execute) && isStore;

   always_ff @(posedge clk) begin
      if (!reset) begin
         // Start by waiting out any write still in progress
         state <= rvPkg::waitMem;
         pc    <= resetAddr[addrWidth-1:0];
      end else begin
         unique case (state)
            rvPkg::fetchInstr: begin
               state <= rvPkg::waitInstr;
            end
            rvPkg::waitInstr: begin
               if (!memRbusy) begin
                  state <= rvPkg::execute;
               end
            end
            rvPkg::execute: begin
               pc    <= pcNext;
               state <= (isLoad || isStore) ? rvPkg::waitMem : rvPkg::fetchInstr;
            end
            rvPkg::waitMem: begin
               if (!memRbusy && !memWbusy) begin
                  state <= rvPkg::fetchInstr;
               end
            end
         endcase
      end
   end

   // A read strobe never overlaps a store mask or a write still busy in memory
   noReadDuringStore: assert property (
      @(posedge clk) disable iff (!reset) !(memRstrb && (storeEn || memWbusy))
   );

endmodule

// File: verilog/femtoCore.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multi-cycle RV32I core, top level
// One shared memory port for fetch and
// data, busy levels from memory
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module femtoCore #(
   parameter rvPkg::wordT resetAddr = '0,
   // Internal address width, upper bus bits are zero
   parameter int          addrWidth = 24
) (
   input  logic            clk,
   input  logic            reset,
   output rvPkg::wordT     memAddr,
   output rvPkg::wordT     memWdata,
   output rvPkg::byteMaskT memWmask,
   input  rvPkg::wordT     memRdata,
   output logic            memRstrb,
   input  logic            memRbusy,
   input  logic            memWbusy
);

   // Decoded instruction shared by the datapath blocks
   decodeIf dec ();

   logic        instrLoad;
   logic        wrEn;
   rvPkg::wordT wrData;
   rvPkg::wordT rs1Val;
   rvPkg::wordT rs2Val;
   rvPkg::wordT aluOut;
   rvPkg::wordT sum;
   logic        takeBranch;
   rvPkg::wordT lsAddr;
   rvPkg::wordT loadData;
   logic        storeEn;

   instrDecode u_instrDecode (
      .clk       (clk),
      .instrLoad (instrLoad),
      .memRdata  (memRdata),
      .dec       (dec.src)
   );

   // Destination id comes from the latched instruction
   regFile u_regFile (
      .clk       (clk),
      .instrLoad (instrLoad),
      .memRdata  (memRdata),
      .wrEn      (wrEn),
      .wrId      (dec.rdId),
      .wrData    (wrData),
      .rs1Val    (rs1Val),
      .rs2Val    (rs2Val)
   );

   aluUnit u_aluUnit (
      .rs1Val     (rs1Val),
      .rs2Val     (rs2Val),
      .dec        (dec.dst),
      .aluOut     (aluOut),
      .sum        (sum),
      .takeBranch (takeBranch)
   );

   loadStore #(
      .addrWidth (addrWidth)
   ) u_loadStore (
      .rs1Val   (rs1Val),
      .rs2Val   (rs2Val),
      .memRdata (memRdata),
      .storeEn  (storeEn),
      .dec      (dec.dst),
      .lsAddr   (lsAddr),
      .loadData (loadData),
      .memWdata (memWdata),
      .memWmask (memWmask)
   );

   fetchExecCtrl #(
      .resetAddr (resetAddr),
      .addrWidth (addrWidth)
   ) u_fetchExecCtrl (
      .clk        (clk),
      .reset      (reset),
      .dec        (dec.dst),
      .aluOut     (aluOut),
      .sum        (sum),
      .takeBranch (takeBranch),
      .lsAddr     (lsAddr),
      .loadData   (loadData),
      .memRbusy   (memRbusy),
      .memWbusy   (memWbusy),
      .memAddr    (memAddr),
      .memRstrb   (memRstrb),
      .instrLoad  (instrLoad),
      .storeEn    (storeEn),
      .wrEn       (wrEn),
      .wrData     (wrData)
   );

endmodule

// File: sim/tbFemtoCore.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the RV32I core
// Memory model with random busy, program
// generator, reference model and checker
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module tbFemtoCore;

   localparam logic [31:0] tbResetAddr   = 32'h0000_0000;
   localparam int          inDelay       = 1;
   localparam int          timeoutCycles = 100000;
   // x5 points at the result slots, x6 at the sub-word data area
   localparam logic [31:0] resultBase    = 32'h0000_2000;
   localparam logic [31:0] dataBase      = 32'h0000_3000;
   localparam logic [31:0] doneAddr      = 32'h0000_27fc;

   localparam logic [6:0] opcLoad   = 7'b0000011;
   localparam logic [6:0] opcOpImm  = 7'b0010011;
   localparam logic [6:0] opcAuipc  = 7'b0010111;
   localparam logic [6:0] opcStore  = 7'b0100011;
   localparam logic [6:0] opcOp     = 7'b0110011;
   localparam logic [6:0] opcLui    = 7'b0110111;
   localparam logic [6:0] opcBranch = 7'b1100011;
   localparam logic [6:0] opcJalr   = 7'b1100111;
   localparam logic [6:0] opcJal    = 7'b1101111;

   logic        clk;
   logic        reset;
   logic [31:0] memAddr;
   logic [31:0] memWdata;
   logic [3:0]  memWmask;
   logic [31:0] memRdata;
   logic        memRstrb;
   logic        memRbusy;
   logic        memWbusy;

   // 64 KB, the full 16-bit address space
   logic [31:0] mem [0:16383];
   integer      seed;

   // Expected stores in program order
   logic [31:0] expAddr [$];
   logic [3:0]  expMask [$];
   logic [31:0] expData [$];

   logic [31:0] pcW;
   int          slot;
   int          dataIdx;
   int          expIdx     = 0;
   int          errorCount = 0;
   int          checkCount = 0;
   logic        done       = 1'b0;
   logic        fetchSeen  = 1'b0;

   femtoCore #(
      .resetAddr (tbResetAddr),
      .addrWidth (16)
   ) u_femtoCore (
      .clk      (clk),
      .reset    (reset),
      .memAddr  (memAddr),
      .memWdata (memWdata),
      .memWmask (memWmask),
      .memRdata (memRdata),
      .memRstrb (memRstrb),
      .memRbusy (memRbusy),
      .memWbusy (memWbusy)
   );

   // Instruction encoders
   function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] opc);
      return {f7, rs2, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], opcStore};
   endfunction

   function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opcBranch};
   endfunction

   function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] opc);
      return {imm, rd, opc};
   endfunction

   function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opcJal};
   endfunction

   // RV32I integer result, alt selects SUB or SRA
   function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
      logic [4:0] sh;
      sh = b[4:0];
      case (f3)
         3'd0: return alt ? a - b : a + b;
         3'd1: return a << sh;
         3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         3'd3: return (a < b) ? 32'd1 : 32'd0;
         3'd4: return a ^ b;
         3'd5: begin
            // Kept apart so the arithmetic shift stays signed
            if (alt) begin
               return $signed(a) >>> sh;
            end else begin
               return a >> sh;
            end
         end
         3'd6: return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
      case (f3)
         3'd0: return a == b;
         3'd1: return a != b;
         3'd4: return $signed(a) < $signed(b);
         3'd5: return $signed(a) >= $signed(b);
         3'd6: return a < b;
         3'd7: return a >= b;
         default: return 1'b0;
      endcase
   endfunction

   // Byte or halfword from a word, sign- or zero-extended per funct3
   function automatic logic [31:0] loadExtend(input logic [2:0] f3, input logic [31:0] word,
                                              input logic [1:0] off);
      logic [7:0]  bt;
      logic [15:0] hw;
      bt = word[{off, 3'b000} +: 8];
      hw = word[{off[1], 4'b0000} +: 16];
      case (f3)
         3'd0: return {{24{bt[7]}}, bt};
         3'd4: return {24'b0, bt};
         3'd1: return {{16{hw[15]}}, hw};
         3'd5: return {16'b0, hw};
         default: return word;
      endcase
   endfunction

   function automatic logic [31:0] laneBits(input logic [3:0] m);
      return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
   endfunction

   task automatic emit(input logic [31:0] ins);
      mem[pcW[15:2]] = ins;
      pcW = pcW + 32'd4;
   endtask

   task automatic expectStore(input logic [31:0] addr, input logic [3:0] mask,
                              input logic [31:0] data);
      expAddr.push_back(addr);
      expMask.push_back(mask);
      expData.push_back(data);
   endtask

   // LUI then ADDI, upper part rounded for the signed low 12 bits
   task automatic loadReg(input logic [4:0] rd, input logic [31:0] v);
      logic [31:0] upper;
      upper = v + 32'h800;
      emit(encU(upper[31:12], rd, opcLui));
      emit(encI(v[11:0], rd, 3'd0, rd, opcOpImm));
   endtask

   // SW into the next result slot
   task automatic storeReg(input logic [4:0] rs, input logic [31:0] data);
      emit(encS(12'(slot * 4), rs, 5'd5, 3'd2));
      expectStore(resultBase + 32'(slot * 4), 4'hf, data);
      slot++;
   endtask

   task automatic aluRegGroup(input logic [2:0] f3, input logic alt);
      logic [31:0] a;
      logic [31:0] b;
      a = $random(seed);
      b = $random(seed);
      loadReg(5'd1, a);
      loadReg(5'd2, b);
      emit(encR(alt ? 7'b0100000 : 7'b0, 5'd2, 5'd1, f3, 5'd3, opcOp));
      storeReg(5'd3, aluRef(f3, alt, a, b));
   endtask

   task automatic aluImmGroup(input logic [2:0] f3, input logic alt);
      logic [31:0] a;
      logic [11:0] imm;
      a = $random(seed);
      imm = 12'($random(seed));
      // Shift immediates carry funct7 in the upper bits
      if (f3 == 3'd1 || f3 == 3'd5) begin
         imm = {1'b0, alt, 5'b0, imm[4:0]};
      end
      loadReg(5'd1, a);
      emit(encI(imm, 5'd1, f3, 5'd3, opcOpImm));
      storeReg(5'd3, aluRef(f3, alt && (f3 == 3'd5), a, {{20{imm[11]}}, imm}));
   endtask

   // Marker 1 if taken, 2 if the fall-through ADDI runs
   task automatic branchGroup(input logic [2:0] f3);
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] r;
      a = $random(seed);
      b = $random(seed);
      r = $random(seed);
      if (r[0]) begin
         b = a;
      end
      loadReg(5'd1, a);
      loadReg(5'd2, b);
      emit(encI(12'd1, 5'd0, 3'd0, 5'd3, opcOpImm));
      emit(encB(13'd8, 5'd2, 5'd1, f3));
      emit(encI(12'd2, 5'd0, 3'd0, 5'd3, opcOpImm));
      storeReg(5'd3, branchTaken(f3, a, b) ? 32'd1 : 32'd2);
   endtask

   task automatic jumpGroup();
      logic [31:0] pA;
      pA = pcW;
      emit(encJ(21'd8, 5'd3));
      emit(encI(12'd0, 5'd0, 3'd0, 5'd3, opcOpImm));
      storeReg(5'd3, pA + 32'd4);
      // JALR sits after the two LUI/ADDI words, odd target must lose bit 0
      pA = pcW + 32'd8;
      loadReg(5'd1, pA + 32'd6);
      emit(encI(12'd3, 5'd1, 3'd0, 5'd3, opcJalr));
      emit(encI(12'd0, 5'd0, 3'd0, 5'd3, opcOpImm));
      storeReg(5'd3, pA + 32'd4);
   endtask

   task automatic upperGroup();
      logic [19:0] imm;
      logic [31:0] pA;
      imm = 20'($random(seed));
      emit(encU(imm, 5'd3, opcLui));
      storeReg(5'd3, {imm, 12'b0});
      imm = 20'($random(seed));
      pA = pcW;
      emit(encU(imm, 5'd3, opcAuipc));
      // 16-bit internal address width
      storeReg(5'd3, (pA + {imm, 12'b0}) & 32'h0000_ffff);
   endtask

   // Word init, then SB or SH at every offset with signed and unsigned read-back
   task automatic subWordGroup(input logic half);
      logic [31:0] wAddr;
      logic [31:0] word;
      logic [31:0] v;
      logic [11:0] base;
      logic [2:0]  f3;
      int          o;
      base = 12'(dataIdx * 4);
      wAddr = dataBase + 32'(dataIdx * 4);
      dataIdx++;
      f3 = half ? 3'd1 : 3'd0;
      word = $random(seed);
      loadReg(5'd2, word);
      emit(encS(base, 5'd2, 5'd6, 3'd2));
      expectStore(wAddr, 4'hf, word);
      for (o = 0; o < 4; o += (half ? 2 : 1)) begin
         v = $random(seed);
         loadReg(5'd2, v);
         emit(encS(base + 12'(o), 5'd2, 5'd6, f3));
         if (half) begin
            word[8*o +: 16] = v[15:0];
            expectStore(wAddr + 32'(o), 4'b0011 << o, {2{v[15:0]}});
         end else begin
            word[8*o +: 8] = v[7:0];
            expectStore(wAddr + 32'(o), 4'b0001 << o, {4{v[7:0]}});
         end
         emit(encI(base + 12'(o), 5'd6, f3, 5'd3, opcLoad));
         storeReg(5'd3, loadExtend(f3, word, 2'(o)));
         emit(encI(base + 12'(o), 5'd6, f3 | 3'd4, 5'd3, opcLoad));
         storeReg(5'd3, loadExtend(f3 | 3'd4, word, 2'(o)));
      end
      emit(encI(base, 5'd6, 3'd2, 5'd3, opcLoad));
      storeReg(5'd3, word);
   endtask

   // Writes to x0 are dropped
   task automatic zeroRegGroup();
      emit(encI(12'($random(seed)), 5'd0, 3'd0, 5'd0, opcOpImm));
      emit(encR(7'b0, 5'd2, 5'd1, 3'd0, 5'd0, opcOp));
      storeReg(5'd0, 32'd0);
   endtask

   task automatic buildProgram();
      int f;
      pcW = tbResetAddr;
      slot = 0;
      dataIdx = 0;
      emit(encU(20'h2, 5'd5, opcLui));
      emit(encU(20'h3, 5'd6, opcLui));
      repeat (3) begin
         for (f = 0; f < 8; f++) begin
            aluRegGroup(3'(f), 1'b0);
            if (f == 0 || f == 5) begin
               aluRegGroup(3'(f), 1'b1);
            end
         end
         for (f = 0; f < 8; f++) begin
            aluImmGroup(3'(f), 1'b0);
         end
         aluImmGroup(3'd5, 1'b1);
         for (f = 0; f < 8; f++) begin
            if (f != 2 && f != 3) begin
               branchGroup(3'(f));
            end
         end
         jumpGroup();
         upperGroup();
         subWordGroup(1'b0);
         subWordGroup(1'b1);
         zeroRegGroup();
      end
      // End marker store
      emit(encS(12'h7fc, 5'd0, 5'd5, 3'd2));
   endtask

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Memory model, acts on port values sampled mid-cycle
   initial begin : memModel
      logic [31:0] smpAddr;
      logic [31:0] smpWdata;
      logic [3:0]  smpMask;
      logic        smpRstrb;
      logic        smpReset;
      logic [31:0] rdAddr;
      logic [31:0] r;
      logic [1:0]  rdLeft;
      logic [1:0]  wrLeft;
      int          i;
      memRdata = 32'd0;
      memRbusy = 1'b0;
      memWbusy = 1'b0;
      rdAddr = 32'd0;
      rdLeft = 2'd0;
      wrLeft = 2'd0;
      seed = 32'hc51f_aa0b;
      for (i = 0; i < 16384; i++) begin
         mem[i] = {16'(i) ^ 16'ha5c3, 16'(i)};
      end
      buildProgram();
      forever begin
         @(negedge clk);
         smpAddr = memAddr;
         smpWdata = memWdata;
         smpMask = memWmask;
         smpRstrb = memRstrb;
         smpReset = reset;
         @(posedge clk);
         #inDelay;
         if (!smpReset) begin
            rdLeft = 2'd0;
            wrLeft = 2'd0;
         end else begin
            if (smpMask != 4'b0) begin
               for (i = 0; i < 4; i++) begin
                  if (smpMask[i]) begin
                     mem[smpAddr[15:2]][8*i +: 8] = smpWdata[8*i +: 8];
                  end
               end
               r = $random(seed);
               wrLeft = r[2] ? r[1:0] : 2'd0;
            end else if (wrLeft != 2'd0) begin
               wrLeft = wrLeft - 2'd1;
            end
            if (smpRstrb) begin
               rdAddr = smpAddr;
               r = $random(seed);
               rdLeft = r[2] ? r[1:0] : 2'd0;
            end else if (rdLeft != 2'd0) begin
               rdLeft = rdLeft - 2'd1;
            end
         end
         memRbusy = (rdLeft != 2'd0);
         memWbusy = (wrLeft != 2'd0);
         // Junk on the bus until the read completes
         memRdata = memRbusy ? 32'hdead_beef : mem[rdAddr[15:2]];
      end
   end

   // Store checker on the top-level ports
   always @(negedge clk) begin : storeCheck
      logic [31:0] lanes;
      if (reset) begin
         if (memRstrb && !fetchSeen) begin
            fetchSeen = 1'b1;
            checkCount++;
            if (memAddr !== tbResetAddr) begin
               errorCount++;
               $display("ERROR %0t: first fetch at %h, expected %h", $time, memAddr,
                        tbResetAddr);
            end
         end
         if (memWmask != 4'b0) begin
            if (memAddr == doneAddr) begin
               done = 1'b1;
            end else if (expIdx >= expAddr.size()) begin
               errorCount++;
               $display("ERROR %0t: unexpected store to %h", $time, memAddr);
            end else begin
               lanes = laneBits(expMask[expIdx]);
               checkCount++;
               if (memAddr !== expAddr[expIdx] || memWmask !== expMask[expIdx] ||
                   (memWdata & lanes) !== (expData[expIdx] & lanes)) begin
                  errorCount++;
                  $display("ERROR %0t: store %0d at %h mask %b data %h, expected %h %b %h",
                           $time, expIdx, memAddr, memWmask, memWdata, expAddr[expIdx],
                           expMask[expIdx], expData[expIdx]);
               end
               expIdx++;
            end
         end
      end
   end

   initial begin
      int waited;
      int missing;
      int totalErrors;
      reset = 1'b0;
      waited = 0;
      repeat (16) @(posedge clk);
      #inDelay;
      reset = 1'b1;
      while (!done && waited < timeoutCycles) begin
         @(posedge clk);
         waited++;
      end
      totalErrors = errorCount;
      if (!done) begin
         totalErrors++;
         $display("Timeout: no store to the done address within %0d cycles", timeoutCycles);
      end
      missing = expAddr.size() - expIdx;
      if (missing != 0) begin
         totalErrors += missing;
         $display("%0d expected result stores never arrived", missing);
      end
      $display("Checks: %0d, errors: %0d", checkCount, totalErrors);
      if (totalErrors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// File: flist.f
verilog/rvPkg.sv
verilog/decodeIf.sv
verilog/instrDecode.sv
verilog/regFile.sv
verilog/aluUnit.sv
verilog/loadStore.sv
verilog/fetchExecCtrl.sv
verilog/femtoCore.sv
sim/tbFemtoCore.sv

// File: Makefile
# Verilator build and run of the femtoCore testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tbFemtoCore
FLIST     = flist.f
OBJDIR    = obj_dir
SIMBIN    = $(OBJDIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell cat $(FLIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIMBIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: $(SIMBIN)
	./$(SIMBIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "sim passed" $(LOG); then echo "Simulation ended without a verdict"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
